// ==== sim.f ====
verilog/mem_map_pkg.sv
verilog/zx_ports_pkg.sv
verilog/master_config.sv
verilog/paging_regs.sv
verilog/divmmc_control.sv
verilog/address_translator.sv
verilog/cpu_data_mux.sv
verilog/zx_memory_top.sv
tests/sram_model.sv
tests/tb_zx_memory.sv

// ==== Makefile ====
SRCS := $(shell cat sim.f)

.PHONY: run clean

# rebuilt only when a source or the file list changes
obj_dir/Vtb_zx_memory: $(SRCS) sim.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_zx_memory -f sim.f

sim.log: obj_dir/Vtb_zx_memory
	-./obj_dir/Vtb_zx_memory > sim.log 2>&1

run: sim.log
	cat sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_zx_memory.sv ====
`timescale 1ns/1ps

module tb_zx_memory;

   localparam int CLK_NS      = 40;
   localparam int TEST_CYCLES = 400;   // about 3 clocks per bus cycle below

   logic                    clk = 1'b0;
   logic                    mrst_n, rst_n;
   logic [15:0]             a;
   logic [7:0]              din, dout, addr, sram_wdata, sram_rdata;
   logic                    mreq_n, iorq_n, rd_n, wr_n, m1_n;
   logic                    page_configrom_active, ior, iow, oe, enable_nmi_n;
   logic                    in_boot_mode, issue2_keyboard_enabled, disable_contention;
   logic [1:0]              timing_mode;
   logic                    in48kmode, access_to_screen, sram_we_n;
   mem_map_pkg::sram_addr_u sram_addr;

   // reference model state
   logic [7:0] ref_conf, ref_b128, ref_p3, ref_ctrl;
   logic [6:0] ref_mapper;
   logic       ref_paged, ref_pending;
   logic [7:0] shadow [int];   // bytes written through the DUT

   zx_memory_top zx_memory_top_inst (.*);

   sram_model sram_model_inst (
      .addr(sram_addr), .wdata(sram_wdata), .rdata(sram_rdata), .we_n(sram_we_n)
   );

   always #(CLK_NS / 2) clk = ~clk;

   initial begin
      #(TEST_CYCLES * CLK_NS * 2);
      $display("Timeout: the test sequence did not finish in %0d ns", TEST_CYCLES * CLK_NS * 2);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

   task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp) else begin
         $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "stopped at first error");
      end
   endtask

   function automatic logic [15:0] random_offset();   // anywhere in a 16K quarter
      return 16'($urandom_range(0, 16'h3FFF));
   endfunction

   task automatic check_status;
      expect_eq(in_boot_mode, !ref_conf[7], "in_boot_mode");
      expect_eq(in48kmode, ref_b128[5], "in48kmode");
      expect_eq(enable_nmi_n, ref_conf[1] && ref_paged && !ref_conf[2], "enable_nmi_n");
      expect_eq(issue2_keyboard_enabled, ref_conf[3], "issue2_keyboard_enabled");
      expect_eq(disable_contention, ref_conf[5], "disable_contention");
      expect_eq(timing_mode, {ref_conf[6], ref_conf[4]}, "timing_mode");
   endtask

   // ------------------------------
   // expected SRAM address
   // ------------------------------
   task automatic ref_decode(input logic [15:0] ca, output mem_map_pkg::sram_addr_u ea,
                             output logic wr_ok);
      logic [1:0] q;
      logic       mapram_rom;
      q            = ca[15:14];
      mapram_rom   = ref_ctrl[6] && !ref_ctrl[7];
      ea           = '0;
      ea.zx.offset = ca[13:0];
      wr_ok        = 1'b1;
      if (ref_conf[0]) begin                        // boot layout
         case (q)
            2'd0:    ea.zx.page = mem_map_pkg::BOOT_PAGE;
            2'd1:    ea.zx.page = mem_map_pkg::SCREEN_PAGE;
            2'd2:    ea.zx.page = mem_map_pkg::PAGE_FIXED_8000;
            default: ea.zx.page = ref_mapper;
         endcase
         wr_ok = q != 2'd0;
      end else if (q == 2'd0 && ref_conf[1] && (ref_paged || ref_ctrl[7])) begin
         ea.div.offset = ca[12:0];                  // 8K divmmc view
         if (!ca[13]) begin
            ea.div.page = mapram_rom ? mem_map_pkg::DIVMMC_MAPRAM_ROM8
                                     : mem_map_pkg::DIVMMC_ROM_PAGE8;
            wr_ok       = 1'b0;
         end else begin
            ea.div.page = mem_map_pkg::DIVMMC_RAM_BASE8 + 8'(ref_ctrl[3:0]);
            wr_ok       = ref_ctrl[5:0] < 6'd16 && !(mapram_rom && ref_ctrl[5:0] == 6'd3);
         end
      end else if (ref_p3[0]) begin
         case (ref_p3[2:1])                         // 0123, 4567, 4563, 4763
            2'd0:    ea.zx.page = 7'(q);
            2'd1:    ea.zx.page = 7'(q) + 7'd4;
            2'd2:    ea.zx.page = q == 2'd3 ? 7'd3 : 7'(q) + 7'd4;
            default: ea.zx.page = q == 2'd3 ? 7'd3 : q == 2'd1 ? 7'd7 : 7'(q) + 7'd4;
         endcase
      end else begin
         case (q)
            2'd0:    ea.zx.page = mem_map_pkg::ROM_BASE_PAGE + 7'({ref_p3[2], ref_b128[4]});
            2'd1:    ea.zx.page = mem_map_pkg::SCREEN_PAGE;
            2'd2:    ea.zx.page = mem_map_pkg::PAGE_FIXED_8000;
            default: ea.zx.page = 7'(ref_b128[2:0]);
         endcase
         wr_ok = q != 2'd0;
      end
   endtask

   // ------------------------------
   // CPU and register bus cycles
   // ------------------------------
   task automatic mem_access(input logic [15:0] ca, input logic wr, input logic [7:0] data);
      mem_map_pkg::sram_addr_u ea;
      logic ok;
      logic contended;
      int   writes_before;
      int   key;
      ref_decode(ca, ea, ok);
      key           = 32'(ea);
      contended     = !ref_conf[0] && !ref_p3[0]
                      && (ca[15:14] == 2'd1 || (ca[15:14] == 2'd3 && ref_b128[0]));
      writes_before = sram_model_inst.write_count;
      @(posedge clk);
      #2;
      {a, din, mreq_n, rd_n} = {ca, data, 1'b0, wr};   // T1, address out
      @(posedge clk);
      #2;
      wr_n = !wr;                                       // T2, strobe
      @(negedge clk);
      expect_eq(sram_addr, ea, "sram address");
      expect_eq(sram_we_n, !(wr && ok), "sram write strobe");
      expect_eq(access_to_screen, contended, "access_to_screen");
      expect_eq(oe, !wr, "cpu output enable");
      if (!wr && shadow.exists(key))
         expect_eq(dout, shadow[key], "read data");
      @(posedge clk);
      #2;
      {mreq_n, rd_n, wr_n} = 3'b111;
      @(negedge clk);
      expect_eq(sram_model_inst.write_count, writes_before + int'(wr && ok), "write count");
      if (wr && ok) begin
         expect_eq(sram_model_inst.last_addr, ea, "logged write address");
         expect_eq(sram_model_inst.last_data, data, "logged write data");
         shadow[key] = data;
      end
   endtask

   task automatic write_read(input logic [15:0] ca, input logic [7:0] data);
      mem_access(ca, 1'b1, data);
      mem_access(ca, 1'b0, 8'h00);
   endtask

   task automatic io_write(input logic [15:0] port, input logic [7:0] data);
      @(posedge clk);
      #2;
      {a, din, iorq_n, wr_n} = {port, data, 2'b00};
      @(posedge clk);                                   // port write taken here
      #2;
      {iorq_n, wr_n} = 2'b11;
      if (!port[1] && !ref_b128[5]) begin               // +2A decode, 1FFD first
         if (port[15:12] == 4'b0001)
            ref_p3 = data;
         else if (port[15:14] == 2'b01)
            ref_b128 = data;
      end
      if (port[7:0] == 8'hE3)
         ref_ctrl = {data[7], data[6] | ref_ctrl[6], data[5:0]};   // mapram sticks
      @(negedge clk);
      check_status;
   endtask

   task automatic reg_write(input logic [7:0] ra, input logic [7:0] data);
      @(posedge clk);
      #2;
      {addr, din, iow} = {ra, data, 1'b1};
      @(posedge clk);
      #2;
      iow = 1'b0;
      if (ra == 8'h01 && ref_conf[0])
         ref_mapper = data[6:0];
      if (ra == 8'h00) begin
         ref_conf[6:1] = data[6:1];
         if (!ref_conf[7])
            {ref_conf[7], ref_conf[0]} = {data[7], data[0]};
      end
      @(negedge clk);
      check_status;
   endtask

   task automatic reg_read(input logic [7:0] ra);
      @(posedge clk);
      #2;
      {addr, ior} = {ra, 1'b1};
      @(negedge clk);
      expect_eq(oe, 1'b1, "register read enable");
      expect_eq(dout, ra == 8'h00 ? ref_conf : {1'b0, ref_mapper}, "register read data");
      @(posedge clk);
      #2;
      ior = 1'b0;
   endtask

   task automatic m1_fetch(input logic [15:0] ca);
      logic entry;
      entry = ca == 16'h0000 || ca == 16'h0008 || ca == 16'h0038 || ca == 16'h04C6
              || ca == 16'h0562 || (ca == 16'h0066 && !ref_conf[2] && !page_configrom_active);
      @(posedge clk);
      #2;
      {a, mreq_n, rd_n, m1_n} = {ca, 3'b000};
      @(posedge clk);                                   // opcode fetch edge
      if (entry) begin
         ref_pending = 1'b1;
      end else if (ca[15:8] == 8'h3D) begin             // no wait for M1 end
         ref_pending = 1'b1;
         ref_paged   = 1'b1;
      end else if (ca[15:3] == 13'h03FF) begin
         ref_pending = 1'b0;
      end
      @(negedge clk);
      check_status;
      @(posedge clk);
      #2;
      {mreq_n, rd_n, m1_n} = 3'b111;
      @(posedge clk);                                   // first edge with m1_n high
      ref_paged = ref_pending;
      @(negedge clk);
      check_status;
   endtask

   task automatic set_configrom(input logic active);
      @(posedge clk);
      #2;
      page_configrom_active = active;
      repeat (3) @(posedge clk);                        // falling edge needs two samples
      {ref_conf[7], ref_conf[0]} = active ? 2'b01 : 2'b10;
      @(negedge clk);
      check_status;
      reg_read(8'h00);
   endtask

   task automatic soft_reset;
      @(posedge clk);
      #2;
      rst_n = 1'b0;
      @(posedge clk);
      #2;
      rst_n = 1'b1;
      {ref_b128, ref_p3, ref_paged, ref_pending} = '0;
      ref_ctrl = {1'b0, ref_ctrl[6], 6'd0};
      @(negedge clk);
      check_status;
   endtask

   // ------------------------------
   // test sequence
   // ------------------------------
   initial begin
      void'($urandom(78705));
      {mrst_n, rst_n} = 2'b01;
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = '1;
      {a, din, addr, ior, iow, page_configrom_active} = '0;
      {ref_b128, ref_p3, ref_ctrl, ref_mapper, ref_paged, ref_pending} = '0;
      ref_conf = 8'h01;                                 // boot mode, unfrozen
      repeat (2) @(posedge clk);
      #2;
      mrst_n = 1'b1;
      @(negedge clk);
      check_status;

      // boot mode, mapper at C000
      reg_write(8'h01, 8'($urandom_range(16, 127)));
      write_read(16'hC000 | random_offset(), 8'($urandom));
      mem_access(16'h0123, 1'b1, 8'hA5);                // boot page is read only
      reg_write(8'h00, 8'h3B);                          // option bits on, still booting
      reg_read(8'h00);
      reg_read(8'h01);
      reg_write(8'h00, 8'hC2);                          // freeze, divmmc on
      reg_write(8'h00, 8'h03);                          // bits 7 and 0 must hold
      reg_write(8'h01, 8'h7F);
      reg_read(8'h00);
      reg_read(8'h01);

      // config rom edges
      set_configrom(1'b1);
      set_configrom(1'b0);

      // 128K paging and the lock bit
      repeat (4) begin
         io_write(16'h7FFD, 8'($urandom) & 8'h1F);
         write_read(16'hC000 | random_offset(), 8'($urandom));
         mem_access(16'h4000 | random_offset(), 1'b0, 8'h00);
      end
      io_write(16'h7FFD, 8'h21);
      io_write(16'h7FFD, 8'h06);
      io_write(16'h1FFD, 8'h01);
      mem_access(16'hC010, 1'b0, 8'h00);
      soft_reset;

      // +3 all-RAM arrangements, then the four roms
      for (int arr = 0; arr < 4; arr++) begin
         io_write(16'h1FFD, 8'(arr * 2 + 1));
         for (int q = 0; q < 4; q++)
            write_read((16'(q) << 14) | random_offset(), 8'($urandom));
      end
      for (int rom = 0; rom < 4; rom++) begin
         io_write(16'h1FFD, 8'((rom & 2) << 1));
         io_write(16'h7FFD, 8'((rom & 1) << 4));
         mem_access(random_offset(), 1'b1, 8'h5C);
      end

      // divmmc conmem
      io_write(16'h00E3, 8'h80);
      mem_access(16'h0100, 1'b1, 8'h11);
      write_read(16'h2000 | 16'($urandom_range(0, 16'h1FFF)), 8'($urandom));
      io_write(16'h00E3, 8'h93);                        // bank 19, past divmmc ram
      mem_access(16'h2345, 1'b1, 8'h22);

      // automapper
      io_write(16'h00E3, 8'h01);
      m1_fetch(16'h0038);
      write_read(16'h2100, 8'($urandom));
      mem_access(16'h0100, 1'b0, 8'h00);
      m1_fetch(16'h1FF8);
      m1_fetch(16'h3D00 | 16'($urandom_range(0, 255)));
      m1_fetch(16'h1FFF);
      reg_write(8'h00, 8'h06);                          // nmi entry masked
      m1_fetch(16'h0066);
      reg_write(8'h00, 8'h02);
      m1_fetch(16'h0066);

      // mapram across soft reset
      io_write(16'h00E3, 8'h43);
      mem_access(16'h0010, 1'b1, 8'h33);
      mem_access(16'h2010, 1'b1, 8'h44);                // bank 3 holds the rom copy
      soft_reset;
      m1_fetch(16'h0008);
      mem_access(16'h0020, 1'b0, 8'h00);

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== tests/sram_model.sv ====
`timescale 1ns/1ps

module sram_model (
   input  logic [20:0] addr,
   input  logic [7:0]  wdata,
   output logic [7:0]  rdata,
   input  logic        we_n
);

   logic [7:0]  mem [0:(1 << 21) - 1];   // 2 MB, byte wide
   int          write_count;             // write log, read by the testbench
   logic [20:0] last_addr;
   logic [7:0]  last_data;

   // fill byte mixes every address bit
   initial begin
      write_count = 0;
      last_addr   = '0;
      last_data   = '0;
      for (int i = 0; i < (1 << 21); i++)
         mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16) ^ 8'h5A;
   end

   assign rdata = mem[addr];   // asynchronous read

   // data taken as we_n rises, address still held by the cpu
   always @(posedge we_n) begin
      if ($time > 0) begin     // skip the power-up transition
         mem[addr]   = wdata;
         last_addr   = addr;
         last_data   = wdata;
         write_count = write_count + 1;
      end
   end

endmodule

// ==== verilog/zx_memory_top.sv ====
`timescale 1ns/1ps

module zx_memory_top (
   input  logic                     clk,
   input  logic                     mrst_n,      // master reset
   input  logic                     rst_n,       // soft reset
   // CPU bus
   input  logic [15:0]              a,
   input  logic [7:0]               din,
   output logic [7:0]               dout,
   output logic                     oe,
   input  logic                     mreq_n,
   input  logic                     iorq_n,
   input  logic                     rd_n,
   input  logic                     wr_n,
   input  logic                     m1_n,
   output logic                     enable_nmi_n,
   input  logic                     page_configrom_active,
   // status to ULA and keyboard
   output logic                     in_boot_mode,
   output logic                     issue2_keyboard_enabled,
   output logic [1:0]               timing_mode,
   output logic                     disable_contention,
   output logic                     in48kmode,
   output logic                     access_to_screen,
   // core register bus
   input  logic [7:0]               addr,
   input  logic                     ior,
   input  logic                     iow,
   // SRAM
   output mem_map_pkg::sram_addr_u  sram_addr,
   output logic [7:0]               sram_wdata,
   input  logic [7:0]               sram_rdata,
   output logic                     sram_we_n
);

   logic       boot_mode;
   logic [7:0] masterconf_word;
   logic [6:0] mastermapper;
   logic       divmmc_enabled;
   logic       divmmc_nmi_disabled;
   logic [7:0] bank128;
   logic [7:0] bankplus3;
   logic [7:0] divmmc_ctrl;
   logic       divmmc_paged;
   logic       mem_read;

   assign sram_wdata = din;   // write data straight from the cpu

   master_config master_config_inst (
      .clk, .mrst_n, .page_configrom_active, .addr, .iow, .din,
      .boot_mode, .in_boot_mode, .masterconf_word, .mastermapper,
      .divmmc_enabled, .divmmc_nmi_disabled, .issue2_keyboard_enabled,
      .timing_mode, .disable_contention
   );

   paging_regs paging_regs_inst (
      .clk, .mrst_n, .rst_n, .a, .din, .iorq_n, .wr_n,
      .bank128, .bankplus3, .in48kmode
   );

   divmmc_control divmmc_control_inst (
      .clk, .mrst_n, .rst_n, .a, .din, .mreq_n, .iorq_n, .rd_n, .wr_n, .m1_n,
      .divmmc_enabled, .divmmc_nmi_disabled, .page_configrom_active,
      .divmmc_ctrl, .divmmc_paged, .enable_nmi_n
   );

   address_translator address_translator_inst (
      .a, .mreq_n, .rd_n, .wr_n, .boot_mode, .mastermapper, .bank128, .bankplus3,
      .divmmc_ctrl, .divmmc_paged, .divmmc_enabled,
      .sram_addr, .sram_we_n, .mem_read, .access_to_screen
   );

   cpu_data_mux cpu_data_mux_inst (
      .mem_read, .sram_rdata, .addr, .ior, .masterconf_word, .mastermapper,
      .dout, .oe
   );

endmodule

// ==== verilog/cpu_data_mux.sv ====
`timescale 1ns/1ps

module cpu_data_mux (
   input  logic       mem_read,
   input  logic [7:0] sram_rdata,
   input  logic [7:0] addr,
   input  logic       ior,
   input  logic [7:0] masterconf_word,
   input  logic [6:0] mastermapper,
   output logic [7:0] dout,
   output logic       oe
);

   // memory first, then the two core registers
   always_comb begin
      oe   = 1'b1;
      dout = 8'hFF;
      if (mem_read)
         dout = sram_rdata;
      else if (ior && addr == zx_ports_pkg::MASTERCONF_ADDR)
         dout = masterconf_word;
      else if (ior && addr == zx_ports_pkg::MASTERMAPPER_ADDR)
         dout = {1'b0, mastermapper};   // 7-bit page
      else
         oe = 1'b0;                     // bus idle, floats high
   end

endmodule

// ==== verilog/address_translator.sv ====
`timescale 1ns/1ps

module address_translator (
   input  logic [15:0]              a,
   input  logic                     mreq_n,
   input  logic                     rd_n,
   input  logic                     wr_n,
   input  logic                     boot_mode,
   input  logic [6:0]               mastermapper,
   input  logic [7:0]               bank128,
   input  logic [7:0]               bankplus3,
   input  logic [7:0]               divmmc_ctrl,
   input  logic                     divmmc_paged,
   input  logic                     divmmc_enabled,
   output mem_map_pkg::sram_addr_u  sram_addr,
   output logic                     sram_we_n,
   output logic                     mem_read,
   output logic                     access_to_screen
);

   logic [1:0] quarter;
   logic       allram;
   logic [1:0] rom_sel;
   logic       mapram_rom;   // mapram active and conmem off
   logic [5:0] div_bank;
   logic       div_active;
   logic [mem_map_pkg::PAGE16_W-1:0] plus3_page;
   logic [mem_map_pkg::PAGE16_W-1:0] page16;
   logic [mem_map_pkg::PAGE8_W-1:0]  page8;
   logic       use_div;
   logic       writable;

   assign quarter    = a[15:14];
   assign allram     = bankplus3[0];
   assign rom_sel    = {bankplus3[2], bank128[4]};
   assign mapram_rom = divmmc_ctrl[6] && !divmmc_ctrl[7];
   assign div_bank   = divmmc_ctrl[5:0];
   assign div_active = divmmc_enabled && (divmmc_paged || divmmc_ctrl[7]);
   assign plus3_page = mem_map_pkg::PLUS3_ALLRAM[bankplus3[2:1]][quarter];
   assign mem_read   = !mreq_n && !rd_n;

   // ------------------------------
   // page selection per quarter
   // ------------------------------
   always_comb begin
      page16   = plus3_page;
      page8    = mem_map_pkg::DIVMMC_ROM_PAGE8;
      use_div  = 1'b0;
      writable = 1'b1;
      case (quarter)
         2'b00: begin
            if (boot_mode) begin
               page16   = mem_map_pkg::BOOT_PAGE;
               writable = 1'b0;
            end else if (div_active) begin
               use_div = 1'b1;
               if (!a[13]) begin   // 0000-1FFF, rom or mapram bank 3
                  if (mapram_rom)
                     page8 = mem_map_pkg::DIVMMC_MAPRAM_ROM8;
                  writable = 1'b0;
               end else begin      // 2000-3FFF, selected ram bank
                  page8    = mem_map_pkg::DIVMMC_RAM_BASE8 + {4'b0000, div_bank[3:0]};
                  writable = div_bank[5:4] == 2'b00 && !(mapram_rom && div_bank == 6'd3);
               end
            end else if (!allram) begin
               page16   = mem_map_pkg::ROM_BASE_PAGE + {5'b00000, rom_sel};
               writable = 1'b0;
            end
         end
         2'b01: begin
            if (boot_mode || !allram)
               page16 = mem_map_pkg::SCREEN_PAGE;
         end
         2'b10: begin
            if (boot_mode || !allram)
               page16 = mem_map_pkg::PAGE_FIXED_8000;
         end
         default: begin
            if (boot_mode)
               page16 = mastermapper;
            else if (!allram)
               page16 = {4'b0000, bank128[2:0]};
         end
      endcase
   end

   // same 21 bits, filled through the matching view
   always_comb begin
      sram_addr = '0;
      if (use_div) begin
         sram_addr.div.page   = page8;
         sram_addr.div.offset = a[12:0];
      end else begin
         sram_addr.zx.page   = page16;
         sram_addr.zx.offset = a[13:0];
      end
   end

   assign sram_we_n = !(!mreq_n && !wr_n && writable);

   // contended: screen bank and odd banks at C000
   assign access_to_screen = !boot_mode && !allram
                             && (quarter == 2'b01 || (quarter == 2'b11 && bank128[0]));

endmodule

// ==== verilog/divmmc_control.sv ====
`timescale 1ns/1ps

module divmmc_control (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        mreq_n,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        m1_n,
   input  logic        divmmc_enabled,
   input  logic        divmmc_nmi_disabled,
   input  logic        page_configrom_active,
   output logic [7:0]  divmmc_ctrl,    // [7] conmem, [6] mapram, [5:0] bank
   output logic        divmmc_paged,
   output logic        enable_nmi_n    // active high, name kept
);

   logic mapram;
   logic ctrl_write;
   logic fetch;
   logic hit_deferred;
   logic hit_now;
   logic hit_unmap;
   logic pending;    // paging state to apply at M1 end

   assign mapram     = divmmc_ctrl[6];
   assign ctrl_write = !iorq_n && !wr_n && a[7:0] == zx_ports_pkg::DIVMMC_PORT;
   assign enable_nmi_n = divmmc_enabled & divmmc_paged & ~divmmc_nmi_disabled;

   // ------------------------------
   // control port E3
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!mrst_n)
         divmmc_ctrl <= 8'h00;
      else if (!rst_n)
         divmmc_ctrl <= {1'b0, mapram, 6'b000000};   // mapram survives soft reset
      else if (ctrl_write)
         divmmc_ctrl <= {din[7], din[6] | mapram, din[5:0]};   // mapram is set-only
   end

   // ------------------------------
   // automapper
   // ------------------------------
   assign fetch = !mreq_n && !rd_n && !m1_n;

   always_comb begin
      hit_deferred = !divmmc_nmi_disabled && !page_configrom_active
                     && a == zx_ports_pkg::AUTOMAP_NMI;
      for (int i = 0; i < zx_ports_pkg::AUTOMAP_N; i++)
         if (a == zx_ports_pkg::AUTOMAP_ENTRY[i])
            hit_deferred = 1'b1;
   end

   assign hit_now   = a[15:8] == zx_ports_pkg::AUTOMAP_NOW_HI;
   assign hit_unmap = a[15:3] == zx_ports_pkg::UNMAP_HI;

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         pending      <= 1'b0;
         divmmc_paged <= 1'b0;
      end else begin
         if (fetch && hit_deferred) begin
            pending <= 1'b1;
         end else if (fetch && hit_now) begin   // no wait for M1 end
            pending      <= 1'b1;
            divmmc_paged <= 1'b1;
         end else if (fetch && hit_unmap) begin
            pending <= 1'b0;
         end
         if (m1_n)                       // opcode fetched, now switch
            divmmc_paged <= pending;
      end
   end

endmodule

// ==== verilog/paging_regs.sv ====
`timescale 1ns/1ps

module paging_regs (
   input  logic        clk,
   input  logic        mrst_n,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        wr_n,
   output logic [7:0]  bank128,     // port 7FFD
   output logic [7:0]  bankplus3,   // port 1FFD
   output logic        in48kmode
);

   logic io_write;
   logic hit_1ffd;
   logic hit_7ffd;
   logic locked;

   assign io_write = !iorq_n && !wr_n;
   assign locked   = bank128[5];    // paging lock, until next reset
   assign in48kmode = locked;

   // +2A partial decode, a1 low
   assign hit_1ffd = !a[1] && a[15:12] == zx_ports_pkg::PORT_1FFD_HI;
   assign hit_7ffd = !a[1] && a[15:14] == zx_ports_pkg::PORT_7FFD_HI;

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         bank128   <= 8'h00;
         bankplus3 <= 8'h00;
      end else if (io_write && !locked) begin
         if (hit_1ffd)             // 1FFD wins, it also matches 01xx in no case
            bankplus3 <= din;
         else if (hit_7ffd)
            bank128 <= din;
      end
   end

endmodule

// ==== verilog/master_config.sv ====
`timescale 1ns/1ps

module master_config (
   input  logic       clk,
   input  logic       mrst_n,
   input  logic       page_configrom_active,
   input  logic [7:0] addr,
   input  logic       iow,
   input  logic [7:0] din,
   output logic       boot_mode,
   output logic       in_boot_mode,
   output logic [7:0] masterconf_word,
   output logic [6:0] mastermapper,
   output logic       divmmc_enabled,
   output logic       divmmc_nmi_disabled,
   output logic       issue2_keyboard_enabled,
   output logic [1:0] timing_mode,
   output logic       disable_contention
);

   logic [7:0] conf;         // [7] freeze, [0] boot mode
   logic [1:0] cfgrom_hist;  // [1] older sample

   // field breakout of the config word
   assign masterconf_word         = conf;
   assign boot_mode               = conf[0];
   assign in_boot_mode            = ~conf[7];
   assign divmmc_enabled          = conf[1];
   assign divmmc_nmi_disabled     = conf[2];
   assign issue2_keyboard_enabled = conf[3];
   assign disable_contention      = conf[5];
   assign timing_mode             = {conf[6], conf[4]};

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         conf        <= 8'h01;   // boot mode, unfrozen
         cfgrom_hist <= 2'b00;
      end else begin
         cfgrom_hist <= {cfgrom_hist[0], page_configrom_active};
         if (page_configrom_active) begin   // config rom on screen
            conf[7] <= 1'b0;
            conf[0] <= 1'b1;
         end else if (cfgrom_hist == 2'b10) begin   // config rom just left
            conf[7] <= 1'b1;
            conf[0] <= 1'b0;
         end else if (iow && addr == zx_ports_pkg::MASTERCONF_ADDR) begin
            conf[6:1] <= din[6:1];                   // option bits always writable
            if (!conf[7]) begin
               conf[7] <= din[7];
               conf[0] <= din[0];
            end
         end
      end
   end

   // 16K page shown at C000 while booting
   always_ff @(posedge clk) begin
      if (!mrst_n)
         mastermapper <= 7'h00;
      else if (iow && addr == zx_ports_pkg::MASTERMAPPER_ADDR && conf[0])
         mastermapper <= din[6:0];
   end

endmodule

// ==== verilog/zx_ports_pkg.sv ====
package zx_ports_pkg;

   // ------------------------------
   // core register bus
   // ------------------------------
   localparam logic [7:0] MASTERCONF_ADDR   = 8'h00;
   localparam logic [7:0] MASTERMAPPER_ADDR = 8'h01;

   // ------------------------------
   // Z80 I/O ports
   // ------------------------------
   localparam logic [7:0] DIVMMC_PORT = 8'hE3;     // low byte only

   // +2A decode: a1 low plus a top-bits pattern
   localparam logic [1:0] PORT_7FFD_HI = 2'b01;    // a[15:14]
   localparam logic [3:0] PORT_1FFD_HI = 4'b0001;  // a[15:12]

   // ------------------------------
   // DivMMC automapper
   // ------------------------------
   // deferred entries, mapping takes effect after the M1 cycle
   localparam int AUTOMAP_N = 5;
   localparam logic [0:AUTOMAP_N-1][15:0] AUTOMAP_ENTRY = {
      16'h0000, 16'h0008, 16'h0038, 16'h04C6, 16'h0562
   };
   localparam logic [15:0] AUTOMAP_NMI = 16'h0066;   // gated by nmi disable

   localparam logic [7:0]  AUTOMAP_NOW_HI = 8'h3D;   // 3D00-3DFF maps at once
   localparam logic [12:0] UNMAP_HI       = 13'h03FF; // a[15:3] for 1FF8-1FFF

endpackage

// ==== verilog/mem_map_pkg.sv ====
package mem_map_pkg;

   // ------------------------------
   // SRAM geometry
   // ------------------------------
   localparam int SRAM_AW  = 21;                 // 2 MB external SRAM
   localparam int PAGE16_W = 7;                  // 128 pages of 16K
   localparam int PAGE8_W  = 8;                  // 256 pages of 8K

   // fixed 16K pages
   localparam logic [PAGE16_W-1:0] ROM_BASE_PAGE   = 7'd8;   // roms 0..3 at pages 8..11
   localparam logic [PAGE16_W-1:0] BOOT_PAGE       = 7'd13;  // boot code, read only
   localparam logic [PAGE16_W-1:0] SCREEN_PAGE     = 7'd5;
   localparam logic [PAGE16_W-1:0] PAGE_FIXED_8000 = 7'd2;

   // fixed 8K pages for DivMMC
   localparam logic [PAGE8_W-1:0] DIVMMC_ROM_PAGE8   = 8'd24;  // esxdos rom
   localparam logic [PAGE8_W-1:0] DIVMMC_RAM_BASE8   = 8'd32;  // divmmc ram bank 0
   localparam logic [PAGE8_W-1:0] DIVMMC_MAPRAM_ROM8 = 8'd35;  // bank 3, rom in mapram mode

   // +3 all-RAM arrangements, indexed [arrangement][quarter]
   localparam logic [0:3][0:3][PAGE16_W-1:0] PLUS3_ALLRAM = {
      7'd0, 7'd1, 7'd2, 7'd3,
      7'd4, 7'd5, 7'd6, 7'd7,
      7'd4, 7'd5, 7'd6, 7'd3,
      7'd4, 7'd7, 7'd6, 7'd3
   };

   // one SRAM address, seen as 16K spectrum page or 8K divmmc page
   typedef union packed {
      struct packed {
         logic [PAGE16_W-1:0] page;
         logic [13:0]         offset;
      } zx;
      struct packed {
         logic [PAGE8_W-1:0] page;
         logic [12:0]        offset;
      } div;
   } sram_addr_u;

endpackage
